// ==== Bender.yml ====
package:
  name: div_unit

sources:
  - design/div_pkg.sv
  - design/div_step_if.sv
  - design/msb_locator.sv
  - design/div_ctrl.sv
  - design/div_datapath.sv
  - design/div_unit.sv
  - target: simulation
    files:
      - bench/div_checker.sv
      - bench/div_unit_tb.sv

// ==== bench/div_checker.sv ====
`timescale 1ns/1ps

module div_checker (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [3:0]                     op_class,
    input  logic [4:0]                     op_code,
    input  logic                           issue_flush,
    input  logic                           hold,
    input  logic                           kill,
    input  logic [div_pkg::data_width-1:0] dividend,
    input  logic [div_pkg::data_width-1:0] divisor,
    input  logic                           busy,
    input  logic [div_pkg::data_width-1:0] result,
    input  logic [127:0]                   test_name,
    input  int                             test_index,
    input  logic                           check_valid,
    input  logic [div_pkg::data_width-1:0] check_value,
    output int                             value_errors,
    output int                             protocol_errors
);
    import div_pkg::*;

    logic                  issue;
    logic                  pending;       // an issued operation has not completed yet
    logic                  issued_prev;
    logic                  busy_prev;
    logic                  kill_prev;
    logic                  reset_prev;
    logic                  zero_divisor;
    logic [data_width-1:0] reference_value;
    logic [data_width-1:0] last_result;
    int                    busy_cycles;

    // quotient truncates toward zero, remainder takes the dividend's sign
    function automatic logic [data_width-1:0] reference_result(input logic [4:0] op,
        input logic [data_width-1:0] a, input logic [data_width-1:0] b);
        logic signed [data_width-1:0] sa;
        logic signed [data_width-1:0] sb;
        logic                         is_quotient;
        logic                         is_signed;
        sa          = a;
        sb          = b;
        is_quotient = (op == op_div_w) || (op == op_div_wu);
        is_signed   = (op == op_div_w) || (op == op_mod_w);
        if (b == '0)
            return is_quotient ? '0 : a;
        if (is_signed && a == {1'b1, {(data_width-1){1'b0}}} && b == '1)
            return is_quotient ? a : '0;  // overflow case
        case (op)
            op_div_w:  return sa / sb;
            op_mod_w:  return sa % sb;
            op_div_wu: return a / b;
            default:   return a % b;
        endcase
    endfunction

    task automatic value_mismatch(input string what, input logic [data_width-1:0] want,
        input logic [data_width-1:0] got);
        value_errors++;
        $display("error %0s[%0d] %0s expected %h actual %h", test_name, test_index, what,
                 want, got);
    endtask

    task automatic protocol_fault(input string what);
        protocol_errors++;
        $display("%0s[%0d]: %0s", test_name, test_index, what);
    endtask

    assign issue = rst_n && !kill && !busy && (op_class == class_div) && !issue_flush && !hold;

    initial
    begin
        value_errors    = 0;
        protocol_errors = 0;
    end

    // all values read here are the ones settled before this edge
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            pending     = 1'b0;
            issued_prev = 1'b0;
            busy_prev   = 1'b0;
            kill_prev   = 1'b0;
            reset_prev  = 1'b1;
            last_result = '0;
        end
        else
        begin
            if (reset_prev || kill_prev)
            begin
                if (busy !== 1'b0)
                    protocol_fault("busy is high in the cycle after reset or kill");
                if (result !== '0)
                    value_mismatch("cleared result", '0, result);
            end
            else
            begin
                if (busy && !busy_prev && !issued_prev)
                    protocol_fault("busy went high without an issue");
                if (!busy && issued_prev)
                    protocol_fault("busy stayed low after an issue");
                if (!busy && busy_prev && pending)
                begin
                    if (result !== reference_value)
                        value_mismatch("reference", reference_value, result);
                    if (zero_divisor && busy_cycles != 1)
                        protocol_fault($sformatf("zero divisor kept busy high for %0d cycles",
                                                 busy_cycles));
                    pending = 1'b0;
                end
                if (!busy && !busy_prev && !issued_prev && result !== last_result)
                    value_mismatch("held result", last_result, result);
            end

            if (check_valid && result !== check_value)
                value_mismatch("table", check_value, result);

            if (busy)
                busy_cycles++;
            if (kill)
                pending = 1'b0;
            if (issue)
            begin
                reference_value = reference_result(op_code, dividend, divisor);
                zero_divisor    = (divisor == '0);
                busy_cycles     = 0;
                pending         = 1'b1;
            end
            issued_prev = issue;
            busy_prev   = busy;
            kill_prev   = kill;
            reset_prev  = 1'b0;
            last_result = result;
        end
    end

endmodule

// ==== bench/div_unit_tb.sv ====
`timescale 1ns/1ps

module div_unit_tb;
    import div_pkg::*;

    localparam int reset_cycles     = 10;
    localparam int table_len        = 27;
    localparam int random_count     = 40;
    localparam int cycles_per_entry = 40;
    // reset, every entry, one extra entry for the kill case, then margin
    localparam int timeout_limit    = reset_cycles + cycles_per_entry
                                      + (table_len + random_count) * cycles_per_entry + 100;

    localparam logic [2:0] mode_run     = 3'd0;
    localparam logic [2:0] mode_flush   = 3'd1;
    localparam logic [2:0] mode_hold    = 3'd2;
    localparam logic [2:0] mode_class   = 3'd3;  // wrong instruction class
    localparam logic [2:0] mode_kill    = 3'd4;
    localparam logic [2:0] mode_disturb = 3'd5;  // inputs change while busy

    typedef struct packed {
        logic [127:0]          name;
        logic [2:0]            mode;
        logic [4:0]            op;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        logic [data_width-1:0] expected;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic [3:0]            op_class;
    logic [4:0]            op_code;
    logic                  issue_flush;
    logic                  hold;
    logic                  kill;
    logic [data_width-1:0] dividend;
    logic [data_width-1:0] divisor;
    logic                  busy;
    logic [data_width-1:0] result;
    logic [127:0]          test_name;
    int                    test_index;
    logic                  check_valid;
    logic [data_width-1:0] check_value;
    int                    value_errors;
    int                    protocol_errors;
    int                    cycle_count;
    logic [31:0]           rng;
    row_t                  rows[$];

    div_unit    uut (.*);
    div_checker chk (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_limit)
        begin
            $display("timeout: no end of run after %0d cycles", timeout_limit);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_row(input logic [127:0] name, input logic [2:0] mode,
        input logic [4:0] op, input logic [31:0] a, input logic [31:0] b,
        input logic [31:0] expected);
        rows.push_back({name, mode, op, a, b, expected});
    endtask

    task automatic load_table();
        add_row("div_pos",       mode_run,     op_div_w,  32'd100,       32'd7,         32'd14);
        add_row("mod_pos",       mode_run,     op_mod_w,  32'd100,       32'd7,         32'd2);
        add_row("div_negpos",    mode_run,     op_div_w,  32'hffffff9c,  32'd7,   32'hfffffff2);
        add_row("mod_negpos",    mode_run,     op_mod_w,  32'hffffff9c,  32'd7,   32'hfffffffe);
        add_row("div_posneg",    mode_run,     op_div_w,  32'd100, 32'hfffffff9,  32'hfffffff2);
        add_row("mod_posneg",    mode_run,     op_mod_w,  32'd100, 32'hfffffff9,        32'd2);
        add_row("div_negneg",    mode_run,     op_div_w,  32'hffffff9c, 32'hfffffff9,   32'd14);
        add_row("mod_negneg",    mode_run,     op_mod_w,  32'hffffff9c, 32'hfffffff9,
                32'hfffffffe);
        add_row("divu_big",      mode_run,     op_div_wu, 32'hffffffff,  32'd1,   32'hffffffff);
        add_row("modu_big",      mode_run,     op_mod_wu, 32'hffffffff,  32'd16,        32'd15);
        add_row("divu_neg_bits", mode_run,     op_div_wu, 32'hffffff9c,  32'd7,   32'h24924916);
        add_row("modu_neg_bits", mode_run,     op_mod_wu, 32'hffffff9c,  32'd7,          32'd2);
        add_row("div_small",     mode_run,     op_div_w,  32'd5,         32'd9,          32'd0);
        add_row("mod_small",     mode_run,     op_mod_w,  32'hfffffffb,  32'd9,   32'hfffffffb);
        add_row("div_zero",      mode_run,     op_div_w,  32'd1234,      32'd0,          32'd0);
        add_row("mod_zero",      mode_run,     op_mod_w,  32'hfffffb2e,  32'd0,   32'hfffffb2e);
        add_row("modu_zero",     mode_run,     op_mod_wu, 32'hdeadbeef,  32'd0,   32'hdeadbeef);
        add_row("div_ovf",       mode_run,     op_div_w,  32'h80000000, 32'hffffffff,
                32'h80000000);
        add_row("mod_ovf",       mode_run,     op_mod_w,  32'h80000000, 32'hffffffff,   32'd0);
        add_row("divu_ovf_bits", mode_run,     op_div_wu, 32'h80000000, 32'hffffffff,   32'd0);
        add_row("modu_ovf_bits", mode_run,     op_mod_wu, 32'h80000000, 32'hffffffff,
                32'h80000000);
        add_row("flush_blocked", mode_flush,   op_div_w,  32'd50,        32'd5,   32'h80000000);
        add_row("hold_blocked",  mode_hold,    op_div_w,  32'd50,        32'd5,   32'h80000000);
        add_row("class_blocked", mode_class,   op_div_w,  32'd50,        32'd5,   32'h80000000);
        add_row("kill_iter",     mode_kill,    op_div_wu, 32'hffffffff,  32'd1,          32'd0);
        add_row("after_kill",    mode_run,     op_div_wu, 32'd1000,      32'd10,       32'd100);
        add_row("disturb",       mode_disturb, op_mod_wu, 32'd1000,      32'd33,        32'd10);
    endtask

    // op_class is raised for exactly one cycle
    task automatic start_op(input logic [127:0] name, input int index, input logic [4:0] op,
        input logic [31:0] a, input logic [31:0] b);
        @(negedge clk);
        test_name  = name;
        test_index = index;
        op_class   = class_div;
        op_code    = op;
        dividend   = a;
        divisor    = b;
        @(negedge clk);
        op_class = 4'd0;
    endtask

    task automatic run_op(input logic [127:0] name, input int index, input logic [4:0] op,
        input logic [31:0] a, input logic [31:0] b, input logic disturb);
        start_op(name, index, op, a, b);
        while (busy)
        begin
            if (disturb)
            begin
                rng         = xorshift(rng);
                op_code     = {3'd0, rng[1:0]};
                dividend    = rng;
                divisor     = rng >> rng[4:0];
                issue_flush = rng[5];
                op_class    = class_div;  // ignored while busy
            end
            @(negedge clk);
        end
        op_class    = 4'd0;
        issue_flush = 1'b0;
    endtask

    task automatic attempt_blocked(input row_t row, input int index);
        @(negedge clk);
        test_name   = row.name;
        test_index  = index;
        op_class    = (row.mode == mode_class) ? 4'd1 : class_div;
        issue_flush = (row.mode == mode_flush);
        hold        = (row.mode == mode_hold);
        op_code     = row.op;
        dividend    = row.a;
        divisor     = row.b;
        repeat (3) @(negedge clk);
        op_class    = 4'd0;
        issue_flush = 1'b0;
        hold        = 1'b0;
    endtask

    task automatic kill_in_flight(input row_t row, input int index);
        start_op(row.name, index, row.op, row.a, row.b);
        repeat (3) @(negedge clk);  // well inside the iterate state
        kill = 1'b1;
        @(negedge clk);
        kill = 1'b0;
    endtask

    task automatic expect_result(input logic [31:0] value);
        check_valid = 1'b1;
        check_value = value;
        @(negedge clk);
        check_valid = 1'b0;
    endtask

    initial
    begin
        logic [31:0] shape;
        logic [31:0] operand;
        rst_n       = 1'b0;
        op_class    = 4'd0;
        op_code     = 5'd0;
        issue_flush = 1'b0;
        hold        = 1'b0;
        kill        = 1'b0;
        dividend    = '0;
        divisor     = '0;
        test_name   = "reset";
        test_index  = 0;
        check_valid = 1'b0;
        check_value = '0;
        cycle_count = 0;
        rng         = 32'd35;
        load_table();
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < rows.size(); i++)
        begin
            case (rows[i].mode)
                mode_run, mode_disturb:
                    run_op(rows[i].name, i, rows[i].op, rows[i].a, rows[i].b,
                           rows[i].mode == mode_disturb);
                mode_kill:
                    kill_in_flight(rows[i], i);
                default:
                    attempt_blocked(rows[i], i);
            endcase
            expect_result(rows[i].expected);
        end

        // expected values for these come from the checker alone
        for (int i = 0; i < random_count; i++)
        begin
            rng     = xorshift(rng);
            shape   = rng;
            rng     = xorshift(rng);
            operand = rng >> (shape[9] ? shape[8:4] : 5'd0);
            rng     = xorshift(rng);
            run_op("random", i, {3'd0, shape[1:0]}, operand, rng >> shape[14:10], 1'b0);
        end

        repeat (3) @(negedge clk);
        $display("checks done: %0d value errors, %0d protocol errors", value_errors,
                 protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== design/div_ctrl.sv ====
`timescale 1ns/1ps

module div_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] op_class,
    input  logic       issue_flush,
    input  logic       hold,
    input  logic       kill,
    output logic       busy,
    div_step_if.ctrl   step
);
    import div_pkg::*;

    div_state_t state;
    div_state_t state_next;
    logic       issue;

    assign issue = (state == idle) && (op_class == class_div) && !issue_flush && !hold;

    assign busy       = (state != idle);  // doubles as the pipeline stall
    assign step.state = state;

    always_ff @(posedge clk)
    begin
        if (!rst_n || kill)
        begin
            state <= idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next  = state;
        step.load   = 1'b0;
        step.align  = 1'b0;
        step.step   = 1'b0;
        step.finish = 1'b0;

        case (state)
            idle:
            begin
                if (issue)
                begin
                    step.load  = 1'b1;
                    state_next = step.divisor_zero ? drain : align;  // x/0 needs no work
                end
            end

            align:
            begin
                step.align = 1'b1;
                // dividend below divisor, quotient stays zero
                state_next = step.align_negative ? drain : iterate;
            end

            iterate:
            begin
                if (step.counter_negative)
                begin
                    step.finish = 1'b1;
                    state_next  = drain;
                end
                else
                begin
                    step.step = 1'b1;
                end
            end

            drain:
            begin
                state_next = idle;
            end

            default:
            begin
                state_next = idle;
            end
        endcase
    end

endmodule

// ==== design/div_datapath.sv ====
`timescale 1ns/1ps

module div_datapath (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           kill,
    input  logic [4:0]                     op_code,
    input  logic [div_pkg::data_width-1:0] dividend,
    input  logic [div_pkg::data_width-1:0] divisor,
    input  logic [4:0]                     remainder_msb,
    input  logic [4:0]                     divisor_msb,
    output logic [div_pkg::data_width-1:0] remainder_word,
    output logic [div_pkg::data_width-1:0] divisor_word,
    output logic [div_pkg::data_width-1:0] result,
    div_step_if.dpath                      step
);
    import div_pkg::*;

    logic [4:0]             op_reg;
    logic                   dividend_sign;
    logic                   divisor_sign;
    logic [data_width-1:0]  remainder;
    logic [data_width-1:0]  divisor_mag;
    logic [data_width-1:0]  quotient;
    logic [shift_width-1:0] counter;

    logic [shift_width-1:0] align_diff;
    logic [data_width:0]    trial;       // top bit is the borrow
    logic                   signed_load;
    logic                   signed_op;
    logic                   quotient_op;

    assign signed_load = (op_code == op_div_w) || (op_code == op_mod_w);
    assign signed_op   = (op_reg == op_div_w) || (op_reg == op_mod_w);
    assign quotient_op = (op_reg == op_div_w) || (op_reg == op_div_wu);

    // distance between leading ones, negative when dividend < divisor
    assign align_diff = {1'b0, remainder_msb} - {1'b0, divisor_msb};

    assign trial = {1'b0, remainder} - ({1'b0, divisor_mag} << counter[shift_width-2:0]);

    assign step.divisor_zero     = (divisor == '0);
    assign step.counter_negative = counter[shift_width-1];
    assign step.align_negative   = align_diff[shift_width-1];

    assign remainder_word = remainder;
    assign divisor_word   = divisor_mag;

    always_ff @(posedge clk)
    begin
        if (!rst_n || kill)
        begin
            op_reg        <= op_div_w;
            dividend_sign <= 1'b0;
            divisor_sign  <= 1'b0;
            remainder     <= '0;
            divisor_mag   <= '0;
            quotient      <= '0;
            counter       <= '0;
            result        <= '0;
        end
        else
        begin
            if (step.load)
            begin
                op_reg        <= op_code;
                dividend_sign <= dividend[data_width-1];
                divisor_sign  <= divisor[data_width-1];
                quotient      <= '0;
                // a zero divisor skips fixup, so keep the raw dividend then
                if (signed_load && dividend[data_width-1] && !step.divisor_zero)
                    remainder <= -dividend;
                else
                    remainder <= dividend;
                if (signed_load && divisor[data_width-1])
                    divisor_mag <= -divisor;
                else
                    divisor_mag <= divisor;
            end

            if (step.align)
            begin
                counter <= align_diff;
                if (step.align_negative && signed_op && dividend_sign)
                    remainder <= -remainder;  // early exit, fix sign now
            end

            if (step.step)
            begin
                counter  <= counter - 1'b1;
                quotient <= {quotient[data_width-2:0], ~trial[data_width]};
                if (!trial[data_width])
                    remainder <= trial[data_width-1:0];
            end

            if (step.finish)
            begin
                if (signed_op && dividend_sign)
                    remainder <= -remainder;  // remainder follows the dividend
                if (signed_op && (dividend_sign ^ divisor_sign))
                    quotient <= -quotient;
            end

            if (step.state == drain)
                result <= quotient_op ? quotient : remainder;
        end
    end

endmodule

// ==== design/div_pkg.sv ====
package div_pkg;

    // operand and result width
    localparam int unsigned data_width = 32;

    // alignment distance plus a sign bit that marks the end of iteration
    localparam int unsigned shift_width = 6;

    // operation codes, as carried on op_code
    localparam logic [4:0] op_div_w  = 5'd0;  // signed quotient
    localparam logic [4:0] op_mod_w  = 5'd1;  // signed remainder
    localparam logic [4:0] op_div_wu = 5'd2;  // unsigned quotient
    localparam logic [4:0] op_mod_wu = 5'd3;  // unsigned remainder

    // instruction class that issues to the divider
    localparam logic [3:0] class_div = 4'd2;

    typedef enum logic [1:0] {
        idle    = 2'd0,  // waiting for an issue
        align   = 2'd1,  // leading-one difference loaded into the counter
        iterate = 2'd2,  // one shift-subtract per cycle
        drain   = 2'd3   // result register picks up the answer
    } div_state_t;

endpackage

// ==== design/div_step_if.sv ====
`timescale 1ns/1ps

interface div_step_if;
    import div_pkg::*;

    div_state_t state;       // published so the datapath knows when to latch result

    logic load;              // capture operands
    logic align;             // counter <= leading-one difference
    logic step;              // one shift-subtract
    logic finish;            // sign fixup

    logic divisor_zero;
    logic counter_negative;
    logic align_negative;

    modport ctrl (
        output state,
        output load,
        output align,
        output step,
        output finish,
        input  divisor_zero,
        input  counter_negative,
        input  align_negative
    );

    modport dpath (
        input  state,
        input  load,
        input  align,
        input  step,
        input  finish,
        output divisor_zero,
        output counter_negative,
        output align_negative
    );

endinterface

// ==== design/div_unit.sv ====
`timescale 1ns/1ps

module div_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [3:0]                     op_class,
    input  logic [4:0]                     op_code,
    input  logic                           issue_flush,
    input  logic                           hold,
    input  logic                           kill,
    input  logic [div_pkg::data_width-1:0] dividend,
    input  logic [div_pkg::data_width-1:0] divisor,
    output logic                           busy,
    output logic [div_pkg::data_width-1:0] result
);
    import div_pkg::*;

    div_step_if step_bus ();

    logic [data_width-1:0] remainder_word;
    logic [data_width-1:0] divisor_word;
    logic [4:0]            remainder_msb;
    logic [4:0]            divisor_msb;

    div_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_class    (op_class),
        .issue_flush (issue_flush),
        .hold        (hold),
        .kill        (kill),
        .busy        (busy),
        .step        (step_bus)
    );

    div_datapath u_datapath (
        .clk            (clk),
        .rst_n          (rst_n),
        .kill           (kill),
        .op_code        (op_code),
        .dividend       (dividend),
        .divisor        (divisor),
        .remainder_msb  (remainder_msb),
        .divisor_msb    (divisor_msb),
        .remainder_word (remainder_word),
        .divisor_word   (divisor_word),
        .result         (result),
        .step           (step_bus)
    );

    msb_locator u_remainder_locator (
        .word     (remainder_word),
        .position (remainder_msb)
    );

    msb_locator u_divisor_locator (
        .word     (divisor_word),
        .position (divisor_msb)
    );

endmodule

// ==== design/msb_locator.sv ====
`timescale 1ns/1ps

module msb_locator (
    input  logic [div_pkg::data_width-1:0] word,
    output logic [4:0]                     position
);

    logic [15:0] half16;
    logic [7:0]  half8;
    logic [3:0]  half4;
    logic [1:0]  half2;

    // each level keeps the upper half if anything is set there
    always_comb
    begin
        position[4] = |word[31:16];
        half16      = position[4] ? word[31:16] : word[15:0];

        position[3] = |half16[15:8];
        half8       = position[3] ? half16[15:8] : half16[7:0];

        position[2] = |half8[7:4];
        half4       = position[2] ? half8[7:4] : half8[3:0];

        position[1] = |half4[3:2];
        half2       = position[1] ? half4[3:2] : half4[1:0];

        position[0] = half2[1];  // zero word falls through to position 0
    end

endmodule

// ==== sources.f ====
design/div_pkg.sv
design/div_step_if.sv
design/msb_locator.sv
design/div_ctrl.sv
design/div_datapath.sv
design/div_unit.sv
bench/div_checker.sv
bench/div_unit_tb.sv
